// File: Bender.yml
package:
  name: cpuPipeline

sources:
  - files:
      - source/cpuPkg.sv
      - source/alu.sv
      - source/multDiv.sv
      - source/regFile.sv
      - source/wordRam.sv
      - source/processor.sv
      - source/cpuTop.sv
  - target: test
    files:
      - sim/cpuTop_chk.sv
      - sim/cpuTb.sv

// File: sim.f
source/cpuPkg.sv
source/alu.sv
source/multDiv.sv
source/regFile.sv
source/wordRam.sv
source/processor.sv
source/cpuTop.sv
sim/cpuTop_chk.sv
sim/cpuTb.sv

// File: sim/cpuTb.sv
/*
 * cpuTb
 * Directed testbench for the five-stage core. Each test loads a small
 * program while reset is held, releases reset and checks every
 * register-file write in order against values worked out from the ISA
 */
`timescale 1ns/1ps

module cpuTb import cpuPkg::*; ();

    localparam int clockPeriod   = 8;
    localparam int numTests      = 6;
    localparam int cyclesPerTest = 400;
    localparam int runLimit      = 300;    // Cycles before a program counts as hung
    localparam int quietCycles   = 12;     // Stray-write window after the last write

    logic    clock;
    logic    reset;
    logic    progWrite;
    wordT    progAddress;
    wordT    progData;
    logic    regWriteEnable;
    regAddrT regWriteReg;
    wordT    regWriteData;

    wordT    prog [$];      // Program image
    regAddrT expReg [$];    // Expected writes, in order
    wordT    expVal [$];
    int      seed = 13;
    int      errors = 0;
    int      testsRun = 0;
    int      testsFailed = 0;

    cpuTop uut (
        .clock          (clock),
        .reset          (reset),
        .progWrite      (progWrite),
        .progAddress    (progAddress),
        .progData       (progData),
        .regWriteEnable (regWriteEnable),
        .regWriteReg    (regWriteReg),
        .regWriteData   (regWriteData)
    );

    initial begin
        clock = 1'b0;
        forever #(clockPeriod / 2) clock = ~clock;
    end

    // Watchdog over all tests
    initial begin
        #(numTests * cyclesPerTest * clockPeriod);
        $display("Watchdog expired, the run went past its time limit");
        $display("TEST FAILED");
        $finish;
    end

    // Instruction encoders
    function automatic wordT immInstr(opcodeT op, regAddrT rd, regAddrT rs, int imm);
        return {op, rd, rs, imm[16:0]};
    endfunction

    function automatic wordT regInstr(aluOpT fn, regAddrT rd, regAddrT rs, regAddrT rt,
                                      logic [4:0] shamt);
        return {opRtype, rd, rs, rt, shamt, fn, 2'b00};
    endfunction

    function automatic wordT jumpInstr(int target);
        return {opJump, target[26:0]};
    endfunction

    task automatic clearProgram();
        prog.delete();
        expReg.delete();
        expVal.delete();
    endtask

    task automatic emit(wordT instr);
        prog.push_back(instr);
    endtask

    task automatic expectWrite(regAddrT r, wordT v);
        expReg.push_back(r);
        expVal.push_back(v);
    endtask

    task automatic appendSelfJump();
        emit(jumpInstr(prog.size()));   // Parks the core at the end
    endtask

    // Load under reset, release, then follow the write port
    task automatic runProgram(input string name);
        int idx;
        int cycles;
        int errorsBefore;
        idx = 0;
        cycles = 0;
        errorsBefore = errors;
        @(posedge clock);
        reset <= 1'b1;
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge clock);
            progWrite   <= 1'b1;
            progAddress <= wordT'(i);
            progData    <= prog[i];
        end
        @(posedge clock);
        progWrite <= 1'b0;
        repeat (3) @(posedge clock);     // At least 3 reset cycles
        reset <= 1'b0;
        while (idx < expReg.size() && cycles < runLimit) begin
            @(negedge clock);            // Write port is stable mid-cycle
            cycles++;
            if (regWriteEnable) begin
                assert (regWriteReg == expReg[idx]) else begin
                    $display("[FAIL] %0t regWriteReg: got r%0d expected r%0d",
                             $time, regWriteReg, expReg[idx]);
                    errors++;
                end
                assert (regWriteData == expVal[idx]) else begin
                    $display("[FAIL] %0t regWriteData: got 0x%08h expected 0x%08h",
                             $time, regWriteData, expVal[idx]);
                    errors++;
                end
                idx++;
            end
        end
        assert (idx == expReg.size()) else begin
            $display("%s: program did not finish, %0d of %0d writes seen in %0d cycles",
                     name, idx, expReg.size(), cycles);
            errors++;
        end
        repeat (quietCycles) begin
            @(negedge clock);
            assert (!regWriteEnable) else begin
                $display("%s: unexpected write to r%0d after the last expected write",
                         name, regWriteReg);
                errors++;
            end
        end
        testsRun++;
        if (errors == errorsBefore) begin
            $display("Test %0d %-10s pass, %0d writes checked", testsRun, name, idx);
        end else begin
            testsFailed++;
            $display("Test %0d %-10s fail, %0d errors", testsRun, name, errors - errorsBefore);
        end
    endtask

    // Each step uses the previous result
    task automatic aluChainTest();
        wordT r [1:9];
        r[1] = 32'h0000_1234;
        r[2] = wordT'(-100);
        r[3] = r[1] + r[2];
        r[4] = r[3] - r[2];
        r[5] = r[4] & r[2];
        r[6] = r[5] | r[1];
        r[7] = r[6] << 4;
        r[8] = r[2] - r[7];
        r[9] = {{3{r[8][31]}}, r[8][31:3]};    // Sign copied into the top bits
        clearProgram();
        emit(immInstr(opAddi, 5'd1, 5'd0, r[1]));
        emit(immInstr(opAddi, 5'd2, 5'd0, -100));
        emit(regInstr(aluAdd, 5'd3, 5'd1, 5'd2, 5'd0));
        emit(regInstr(aluSub, 5'd4, 5'd3, 5'd2, 5'd0));
        emit(regInstr(aluAnd, 5'd5, 5'd4, 5'd2, 5'd0));
        emit(regInstr(aluOr,  5'd6, 5'd5, 5'd1, 5'd0));
        emit(regInstr(aluSll, 5'd7, 5'd6, 5'd0, 5'd4));
        emit(regInstr(aluSub, 5'd8, 5'd2, 5'd7, 5'd0));
        emit(regInstr(aluSra, 5'd9, 5'd8, 5'd0, 5'd3));
        appendSelfJump();
        for (int i = 1; i <= 9; i++) begin
            expectWrite(regAddrT'(i), r[i]);
        end
        runProgram("aluChain");
    endtask

    task automatic memoryTest();
        wordT sum;
        sum = wordT'(777 - 9);
        clearProgram();
        emit(immInstr(opAddi, 5'd1, 5'd0, 40));     // Base address
        emit(immInstr(opAddi, 5'd2, 5'd0, 777));
        emit(immInstr(opSw,   5'd2, 5'd1, 0));      // mem[40] = r2
        emit(immInstr(opAddi, 5'd3, 5'd0, -9));
        emit(immInstr(opSw,   5'd3, 5'd1, 1));      // mem[41] = r3
        emit(immInstr(opLw,   5'd4, 5'd1, 0));
        emit(immInstr(opLw,   5'd5, 5'd1, 1));
        emit(regInstr(aluAdd, 5'd6, 5'd5, 5'd4, 5'd0));    // Load-use
        emit(immInstr(opSw,   5'd6, 5'd1, 2));
        emit(immInstr(opLw,   5'd7, 5'd1, 2));
        emit(regInstr(aluAdd, 5'd8, 5'd7, 5'd7, 5'd0));
        appendSelfJump();
        expectWrite(5'd1, 32'd40);
        expectWrite(5'd2, 32'd777);
        expectWrite(5'd3, wordT'(-9));
        expectWrite(5'd4, 32'd777);
        expectWrite(5'd5, wordT'(-9));
        expectWrite(5'd6, sum);
        expectWrite(5'd7, sum);
        expectWrite(5'd8, sum + sum);
        runProgram("memory");
    endtask

    task automatic mulDivTest();
        int   a;
        int   b;
        int   c;
        wordT prod;
        wordT quot;
        a = $random(seed) % 60000;      // Fits the 17-bit immediate
        b = $random(seed) % 60000;
        c = $random(seed) % 500;
        if (b == 0) begin
            b = 7;
        end
        if (c == 0) begin
            c = 3;
        end
        prod = wordT'(a * b);           // Low word only
        quot = wordT'($signed(prod) / c);
        clearProgram();
        emit(immInstr(opAddi, 5'd1, 5'd0, a));
        emit(immInstr(opAddi, 5'd2, 5'd0, b));
        emit(regInstr(aluMul, 5'd3, 5'd1, 5'd2, 5'd0));
        emit(regInstr(aluAdd, 5'd4, 5'd3, 5'd1, 5'd0));
        emit(immInstr(opAddi, 5'd5, 5'd0, c));
        emit(regInstr(aluDiv, 5'd6, 5'd3, 5'd5, 5'd0));
        emit(regInstr(aluAdd, 5'd7, 5'd6, 5'd6, 5'd0));
        emit(regInstr(aluDiv, 5'd8, 5'd1, 5'd2, 5'd0));
        appendSelfJump();
        expectWrite(5'd1, wordT'(a));
        expectWrite(5'd2, wordT'(b));
        expectWrite(5'd3, prod);
        expectWrite(5'd4, prod + wordT'(a));
        expectWrite(5'd5, wordT'(c));
        expectWrite(5'd6, quot);
        expectWrite(5'd7, quot + quot);
        expectWrite(5'd8, wordT'(a / b));   // Truncates toward zero
        runProgram("mulDiv");
    endtask

    task automatic branchTest();
        clearProgram();
        emit(immInstr(opAddi, 5'd1, 5'd0, 10));
        emit(immInstr(opAddi, 5'd2, 5'd0, 10));
        emit(immInstr(opBne,  5'd1, 5'd2, 2));      // Equal, falls through
        emit(immInstr(opAddi, 5'd3, 5'd0, 3));
        emit(immInstr(opAddi, 5'd4, 5'd0, 4));
        emit(immInstr(opBne,  5'd3, 5'd4, 2));      // Taken to 8
        emit(immInstr(opAddi, 5'd5, 5'd0, 55));
        emit(immInstr(opAddi, 5'd6, 5'd0, 66));
        emit(immInstr(opAddi, 5'd7, 5'd0, 77));
        appendSelfJump();
        expectWrite(5'd1, 32'd10);
        expectWrite(5'd2, 32'd10);
        expectWrite(5'd3, 32'd3);
        expectWrite(5'd4, 32'd4);
        expectWrite(5'd7, 32'd77);
        runProgram("branch");
    endtask

    task automatic jumpTest();
        clearProgram();
        emit(immInstr(opAddi, 5'd1, 5'd0, 1));
        emit(jumpInstr(4));
        emit(immInstr(opAddi, 5'd2, 5'd0, 2));      // Skipped
        emit(immInstr(opAddi, 5'd3, 5'd0, 3));      // Skipped
        emit(immInstr(opAddi, 5'd4, 5'd1, 40));
        emit(jumpInstr(7));
        emit(immInstr(opAddi, 5'd5, 5'd0, 5));      // Skipped
        emit(regInstr(aluAdd, 5'd6, 5'd4, 5'd1, 5'd0));
        appendSelfJump();
        expectWrite(5'd1, 32'd1);
        expectWrite(5'd4, 32'd41);
        expectWrite(5'd6, 32'd42);
        runProgram("jump");
    endtask

    task automatic divZeroTest();
        clearProgram();
        emit(immInstr(opAddi, 5'd1, 5'd0, 1234));
        emit(immInstr(opAddi, 5'd2, 5'd0, 5));
        emit(regInstr(aluDiv, 5'd2, 5'd1, 5'd0, 5'd0));    // Divisor r0
        emit(immInstr(opAddi, 5'd0, 5'd0, 99));            // No write event
        emit(regInstr(aluAdd, 5'd3, 5'd0, 5'd1, 5'd0));    // r0 still 0
        emit(immInstr(opAddi, 5'd4, 5'd0, 7));
        emit(immInstr(opAddi, 5'd5, 5'd0, 0));
        emit(regInstr(aluDiv, 5'd6, 5'd4, 5'd5, 5'd0));
        emit(regInstr(aluAdd, 5'd7, 5'd6, 5'd4, 5'd0));
        appendSelfJump();
        expectWrite(5'd1, 32'd1234);
        expectWrite(5'd2, 32'd5);
        expectWrite(5'd2, 32'd0);
        expectWrite(5'd3, 32'd1234);
        expectWrite(5'd4, 32'd7);
        expectWrite(5'd5, 32'd0);
        expectWrite(5'd6, 32'd0);
        expectWrite(5'd7, 32'd7);
        runProgram("divZero");
    endtask

    initial begin
        reset       = 1'b1;
        progWrite   = 1'b0;
        progAddress = '0;
        progData    = '0;
        aluChainTest();
        memoryTest();
        mulDivTest();
        branchTest();
        jumpTest();
        divZeroTest();
        $display("%0d tests run, %0d failed, %0d check errors", testsRun, testsFailed, errors);
        if (testsFailed == 0 && errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: sim/cpuTop_chk.sv
/*
 * cpuTop_chk
 * Concurrent checks on the core's control outputs, bound into processor
 */
`timescale 1ns/1ps

module cpuTop_chk import cpuPkg::*; (
    input logic clock,
    input logic reset,
    input logic writeEnable,
    input wordT xmInstr,        // Instruction in memory stage
    input logic dmemWrite,
    input wordT imemAddress,
    input logic mdBusy,
    input logic mdReady
);

    // A bubble leaving memory never writes in writeback
    bubbleNoWrite: assert property (@(posedge clock) disable iff (reset)
        (xmInstr == nopInstr) |=> !writeEnable)
        else $error("register write enabled for a bubble in writeback");

    // Memory stage holds a bubble right after reset
    noStoreAfterReset: assert property (@(posedge clock)
        reset |=> !dmemWrite)
        else $error("data memory write in the cycle after reset");

    // Fetch frozen while mul/div runs
    fetchHeldInMulDiv: assert property (@(posedge clock) disable iff (reset)
        (mdBusy && !mdReady) |=> $stable(imemAddress))
        else $error("instruction address moved during a multiply or divide");

endmodule

bind processor cpuTop_chk chk (
    .clock       (clock),
    .reset       (reset),
    .writeEnable (writeEnable),
    .xmInstr     (xm.instr),
    .dmemWrite   (dmemWrite),
    .imemAddress (imemAddress),
    .mdBusy      (mdBusy),
    .mdReady     (mdReady)
);

// File: source/alu.sv
/*
 * alu
 * Single-cycle integer ALU of the execute stage.
 * Add, sub, and, or, logical left and arithmetic right shift,
 * plus the inequality flag used by bne
 */
`timescale 1ns/1ps

module alu import cpuPkg::*; (
    input  wordT       operandA,
    input  wordT       operandB,
    input  aluOpT      aluOp,
    input  logic [4:0] shamt,
    output wordT       result,
    output logic       isNotEqual
);

    always_comb begin
        case (aluOp)
            aluAdd: begin
                result = operandA + operandB;    // Also addi, lw, sw address
            end
            aluSub: begin
                result = operandA - operandB;
            end
            aluAnd: begin
                result = operandA & operandB;
            end
            aluOr: begin
                result = operandA | operandB;
            end
            aluSll: begin
                result = operandA << shamt;
            end
            aluSra: begin
                result = wordT'($signed(operandA) >>> shamt);   // Sign fills from the left
            end
            default: begin
                result = '0;    // mul and div come from multDiv
            end
        endcase
    end

    // Branch compare for bne
    assign isNotEqual = (operandA != operandB);

endmodule

// File: source/cpuPkg.sv
/*
 * cpuPkg
 * Word types, instruction field layout, opcode and ALU-op encodings
 * and the pipeline latch structs shared by the five-stage core
 */
package cpuPkg;

    typedef logic [31:0] wordT;      // Data word or word address
    typedef logic [4:0]  regAddrT;   // Register number
    typedef logic [4:0]  opcodeT;
    typedef logic [4:0]  aluOpT;

    // Instruction field positions
    localparam int opcodeHi = 31;
    localparam int opcodeLo = 27;
    localparam int rdHi     = 26;
    localparam int rdLo     = 22;
    localparam int rsHi     = 21;
    localparam int rsLo     = 17;
    localparam int rtHi     = 16;
    localparam int rtLo     = 12;
    localparam int shamtHi  = 11;
    localparam int shamtLo  = 7;
    localparam int aluOpHi  = 6;
    localparam int aluOpLo  = 2;
    localparam int immHi    = 16;    // Immediate is [16:0], sign extended
    localparam int targetHi = 26;    // Jump target is [26:0]

    // Opcodes
    localparam opcodeT opRtype = 5'b00000;
    localparam opcodeT opJump  = 5'b00001;
    localparam opcodeT opBne   = 5'b00010;
    localparam opcodeT opAddi  = 5'b00101;
    localparam opcodeT opSw    = 5'b00111;
    localparam opcodeT opLw    = 5'b01000;

    // R-type ALU operations
    localparam aluOpT aluAdd = 5'b00000;
    localparam aluOpT aluSub = 5'b00001;
    localparam aluOpT aluAnd = 5'b00010;
    localparam aluOpT aluOr  = 5'b00011;
    localparam aluOpT aluSll = 5'b00100;
    localparam aluOpT aluSra = 5'b00101;
    localparam aluOpT aluMul = 5'b00110;
    localparam aluOpT aluDiv = 5'b00111;

    localparam int   memDepthLog = 8;    // 256 words per memory
    localparam wordT nopInstr    = '0;   // add r0, r0, r0

    // Pipeline latches
    typedef struct packed {
        wordT pc;
        wordT instr;
    } fdLatchT;

    typedef struct packed {
        wordT pc;
        wordT instr;
        wordT operandA;
        wordT operandB;
    } dxLatchT;

    typedef struct packed {
        wordT instr;
        wordT result;       // ALU result or memory address
        wordT storeData;
    } xmLatchT;

    typedef struct packed {
        wordT instr;
        wordT result;
        wordT loadData;
    } mwLatchT;

endpackage

// File: source/cpuTop.sv
/*
 * cpuTop
 * Top level of the core. Connects the pipeline to its register file,
 * instruction memory and data memory. Instruction memory is loaded
 * through the program port while reset is held
 */
`timescale 1ns/1ps

module cpuTop import cpuPkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  logic    progWrite,
    input  wordT    progAddress,
    input  wordT    progData,
    output logic    regWriteEnable,
    output regAddrT regWriteReg,
    output wordT    regWriteData
);

    wordT    imemAddress, imemData;
    wordT    dmemAddress, dmemWriteData, dmemReadData;
    logic    dmemWrite;
    regAddrT readRegA, readRegB;
    wordT    readDataA, readDataB;

    processor core (
        .clock         (clock),
        .reset         (reset),
        .imemAddress   (imemAddress),
        .imemData      (imemData),
        .dmemAddress   (dmemAddress),
        .dmemWriteData (dmemWriteData),
        .dmemWrite     (dmemWrite),
        .dmemReadData  (dmemReadData),
        .readRegA      (readRegA),
        .readRegB      (readRegB),
        .readDataA     (readDataA),
        .readDataB     (readDataB),
        .writeEnable   (regWriteEnable),    // Write port also exported
        .writeReg      (regWriteReg),
        .writeData     (regWriteData)
    );

    regFile regs (
        .clock       (clock),
        .reset       (reset),
        .readRegA    (readRegA),
        .readRegB    (readRegB),
        .readDataA   (readDataA),
        .readDataB   (readDataB),
        .writeEnable (regWriteEnable),
        .writeReg    (regWriteReg),
        .writeData   (regWriteData)
    );

    // Program load only honored in reset
    wordRam instrMem (
        .clock        (clock),
        .write        (progWrite && reset),
        .writeAddress (progAddress),
        .writeData    (progData),
        .readAddress  (imemAddress),
        .readData     (imemData)
    );

    wordRam dataMem (
        .clock        (clock),
        .write        (dmemWrite),
        .writeAddress (dmemAddress),
        .writeData    (dmemWriteData),
        .readAddress  (dmemAddress),
        .readData     (dmemReadData)
    );

endmodule

// File: source/multDiv.sv
/*
 * multDiv
 * Iterative signed multiplier and divider.
 * Runs 32 shift-add or restoring-division steps on operand magnitudes,
 * then fixes the sign. Start is a one-cycle pulse, ready pulses with result
 */
`timescale 1ns/1ps

module multDiv import cpuPkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic start,
    input  logic isDiv,
    input  wordT operandA,
    input  wordT operandB,
    output wordT result,
    output logic ready
);

    typedef enum logic [1:0] {idle, busy, done} stateT;

    stateT       state;
    logic  [4:0] step;          // Iteration count
    logic        isDivOp;
    logic        negate;        // Operand signs differ
    logic        divByZero;
    wordT        magB;          // Multiplicand or divisor magnitude
    wordT        work;          // Multiplier, then quotient
    wordT        acc;           // Partial product
    wordT        rem;           // Partial remainder
    wordT        raw;
    logic [32:0] remShift;
    logic [32:0] remDiff;

    assign remShift = {rem, work[31]};          // Bring down next dividend bit
    assign remDiff  = remShift - {1'b0, magB};  // Negative means no subtract

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= idle;
            step  <= '0;
        end else begin
            case (state)
                idle: begin
                    if (start) begin
                        state <= busy;
                        step  <= '0;
                    end
                end
                busy: begin
                    step <= step + 5'd1;
                    if (step == 5'd31) begin
                        state <= done;
                    end
                end
                default: state <= idle;     // done lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == idle && start) begin
            isDivOp   <= isDiv;
            negate    <= operandA[31] ^ operandB[31];
            divByZero <= isDiv && (operandB == '0);
            work      <= operandA[31] ? -operandA : operandA;
            magB      <= operandB[31] ? -operandB : operandB;
            acc       <= '0;
            rem       <= '0;
        end else if (state == busy) begin
            if (isDivOp) begin
                rem  <= remDiff[32] ? remShift[31:0] : remDiff[31:0];
                work <= {work[30:0], ~remDiff[32]};    // Quotient bit
            end else begin
                if (work[0]) begin
                    acc <= acc + magB;
                end
                magB <= magB << 1;
                work <= work >> 1;
            end
        end
    end

    assign raw    = isDivOp ? work : acc;
    assign result = divByZero ? '0 : (negate ? -raw : raw);    // Low 32 bits for mul
    assign ready  = (state == done);

endmodule

// File: source/processor.sv
/*
 * processor
 * Five-stage pipelined core: fetch, decode, execute, memory, writeback.
 * Bypasses from memory and writeback, stalls on load-use and while the
 * multiplier/divider works, flushes two slots on taken bne and j.
 * Register file and memories live outside
 */
`timescale 1ns/1ps

module processor import cpuPkg::*; (
    input  logic    clock,
    input  logic    reset,
    output wordT    imemAddress,
    input  wordT    imemData,
    output wordT    dmemAddress,
    output wordT    dmemWriteData,
    output logic    dmemWrite,
    input  wordT    dmemReadData,
    output regAddrT readRegA,
    output regAddrT readRegB,
    input  wordT    readDataA,
    input  wordT    readDataB,
    output logic    writeEnable,
    output regAddrT writeReg,
    output wordT    writeData
);

    function automatic opcodeT opOf(wordT instr);
        return instr[opcodeHi:opcodeLo];
    endfunction

    function automatic regAddrT rdOf(wordT instr);
        return instr[rdHi:rdLo];
    endfunction

    // Second source register is rd for sw data and the bne compare
    function automatic regAddrT srcBOf(wordT instr);
        opcodeT op;
        op = opOf(instr);
        return (op == opSw || op == opBne) ? instr[rdHi:rdLo] : instr[rtHi:rtLo];
    endfunction

    // Destination written and not r0, so bubbles never write
    function automatic logic writesReg(wordT instr);
        opcodeT op;
        op = opOf(instr);
        return (op == opRtype || op == opAddi || op == opLw) && (rdOf(instr) != '0);
    endfunction

    wordT    pc;
    fdLatchT fd;
    dxLatchT dx;
    xmLatchT xm;
    mwLatchT mw;

    opcodeT  opX;
    aluOpT   aluOpX, aluSel;
    regAddrT srcAX, srcBX;
    wordT    opA, opB;          // Bypassed operands
    wordT    immX, aluB, aluResult, mdResult, exResult, branchTarget;
    logic    isNotEqual, takenX, isMulDivX;
    logic    mdStart, mdReady, mdBusy, mdStall, loadUse, frontHold;

    // Fetch
    assign imemAddress = pc;

    // Decode
    assign readRegA = fd.instr[rsHi:rsLo];
    assign readRegB = srcBOf(fd.instr);

    // Load result not ready for the next instruction
    assign loadUse = (opOf(dx.instr) == opLw) && writesReg(dx.instr) &&
                     (rdOf(dx.instr) == readRegA || rdOf(dx.instr) == readRegB);

    // Execute decode
    assign opX    = opOf(dx.instr);
    assign aluOpX = dx.instr[aluOpHi:aluOpLo];
    assign srcAX  = dx.instr[rsHi:rsLo];
    assign srcBX  = srcBOf(dx.instr);
    assign immX   = {{15{dx.instr[immHi]}}, dx.instr[immHi:0]};

    // Bypass, memory stage wins over writeback
    always_comb begin
        opA = dx.operandA;
        if (writesReg(xm.instr) && rdOf(xm.instr) == srcAX) begin
            opA = xm.result;
        end else if (writesReg(mw.instr) && rdOf(mw.instr) == srcAX) begin
            opA = writeData;
        end
        opB = dx.operandB;
        if (writesReg(xm.instr) && rdOf(xm.instr) == srcBX) begin
            opB = xm.result;
        end else if (writesReg(mw.instr) && rdOf(mw.instr) == srcBX) begin
            opB = writeData;
        end
    end

    assign aluSel = (opX == opRtype) ? aluOpX : aluAdd;
    assign aluB   = (opX == opAddi || opX == opLw || opX == opSw) ? immX : opB;

    alu execAlu (
        .operandA   (opA),
        .operandB   (aluB),
        .aluOp      (aluSel),
        .shamt      (dx.instr[shamtHi:shamtLo]),
        .result     (aluResult),
        .isNotEqual (isNotEqual)
    );

    assign isMulDivX = (opX == opRtype) && (aluOpX == aluMul || aluOpX == aluDiv);
    assign mdStart   = isMulDivX && !mdBusy;    // One pulse per mul/div
    assign mdStall   = isMulDivX && !mdReady;

    multDiv execMultDiv (
        .clock    (clock),
        .reset    (reset),
        .start    (mdStart),
        .isDiv    (aluOpX == aluDiv),
        .operandA (opA),
        .operandB (opB),
        .result   (mdResult),
        .ready    (mdReady)
    );

    always_ff @(posedge clock) begin
        if (reset) begin
            mdBusy <= 1'b0;
        end else if (mdStart) begin
            mdBusy <= 1'b1;
        end else if (mdReady) begin
            mdBusy <= 1'b0;
        end
    end

    assign exResult = isMulDivX ? mdResult : aluResult;    // Also the lw/sw address

    // Branch and jump resolve here
    assign takenX       = (opX == opJump) || (opX == opBne && isNotEqual);
    assign branchTarget = (opX == opJump) ? {5'b0, dx.instr[targetHi:0]} : dx.pc + 32'd1 + immX;
    assign frontHold    = mdStall || loadUse;

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;
            fd <= '{pc: '0, instr: nopInstr};
            dx <= '{pc: '0, instr: nopInstr, operandA: '0, operandB: '0};
            xm <= '{instr: nopInstr, result: '0, storeData: '0};
            mw <= '{instr: nopInstr, result: '0, loadData: '0};
        end else begin
            if (!frontHold) begin
                pc <= takenX ? branchTarget : pc + 32'd1;
            end
            if (takenX) begin
                fd <= '{pc: '0, instr: nopInstr};       // Flush younger fetch
            end else if (!frontHold) begin
                fd <= '{pc: pc, instr: imemData};
            end
            if (mdStall) begin
                dx.operandA <= opA;     // Keep operands stable and current
                dx.operandB <= opB;
            end else if (loadUse || takenX) begin
                dx <= '{pc: '0, instr: nopInstr, operandA: '0, operandB: '0};
            end else begin
                dx <= '{pc: fd.pc, instr: fd.instr, operandA: readDataA, operandB: readDataB};
            end
            if (mdStall) begin
                xm <= '{instr: nopInstr, result: '0, storeData: '0};
            end else begin
                xm <= '{instr: dx.instr, result: exResult, storeData: opB};
            end
            mw <= '{instr: xm.instr, result: xm.result, loadData: dmemReadData};
        end
    end

    // Memory
    assign dmemAddress   = xm.result;
    assign dmemWriteData = xm.storeData;
    assign dmemWrite     = (opOf(xm.instr) == opSw);

    // Writeback
    assign writeEnable = writesReg(mw.instr);
    assign writeReg    = rdOf(mw.instr);
    assign writeData   = (opOf(mw.instr) == opLw) ? mw.loadData : mw.result;

endmodule

// File: source/regFile.sv
/*
 * regFile
 * 32-entry register file with two combinational read ports and one
 * write port. r0 reads as zero, same-cycle writes are forwarded
 */
`timescale 1ns/1ps

module regFile import cpuPkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  regAddrT readRegA,
    input  regAddrT readRegB,
    output wordT    readDataA,
    output wordT    readDataB,
    input  logic    writeEnable,
    input  regAddrT writeReg,
    input  wordT    writeData
);

    wordT regs [1:31];      // No storage for r0

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeReg != '0) begin
            regs[writeReg] <= writeData;    // r0 writes dropped
        end
    end

    // Write-through so decode sees writeback in the same cycle
    assign readDataA = (readRegA == '0) ? '0 :
                       (writeEnable && writeReg == readRegA) ? writeData : regs[readRegA];
    assign readDataB = (readRegB == '0) ? '0 :
                       (writeEnable && writeReg == readRegB) ? writeData : regs[readRegB];

endmodule

// File: source/wordRam.sv
/*
 * wordRam
 * Word-addressed memory, combinational read, write on the clock edge.
 * Serves as both instruction and data memory
 */
`timescale 1ns/1ps

module wordRam import cpuPkg::*; (
    input  logic clock,
    input  logic write,
    input  wordT writeAddress,
    input  wordT writeData,
    input  wordT readAddress,
    output wordT readData
);

    wordT mem [2**memDepthLog];

    always_ff @(posedge clock) begin
        if (write) begin
            mem[writeAddress[memDepthLog-1:0]] <= writeData;   // Address wraps at depth
        end
    end

    assign readData = mem[readAddress[memDepthLog-1:0]];

endmodule
